// File: hw/id_pkg.sv
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // link register for jal and jalr
    localparam reg_addr_t RA_REG = 5'd31;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        reg_addr_t  sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fmt_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    localparam logic [5:0] OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03, OP_BEQ    = 6'h04, OP_BNE   = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06, OP_BGTZ   = 6'h07, OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0a, OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f, OP_LW     = 6'h23, OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a, FN_SLTU = 6'h2b;

    // REGIMM selectors in the rt field
    localparam reg_addr_t RT_BLTZ = 5'h00, RT_BGEZ = 5'h01;

    typedef struct packed {
        logic add, sub, slt, sltu, op_and, op_nor, op_or, op_xor, sll, srl, sra, lui;
    } alu_op_t;

    typedef struct packed {
        logic rs, pc, sa;
    } src1_sel_t;

    typedef struct packed {
        logic rt, imm_sext, const8, imm_zext;
    } src2_sel_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ,
        BR_J, BR_JAL, BR_JR, BR_JALR
    } br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        src1_sel_t src1;
        src2_sel_t src2;
        logic      mem_read;
        logic      mem_write;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      sel_rf_res;  // 1 selects load data
    } id_ctrl_t;

    typedef struct packed { logic valid; word_t pc; } fetch_bus_t;
    typedef struct packed { logic we; reg_addr_t waddr; word_t wdata; } fwd_src_t;
    typedef struct packed { logic taken; word_t target; } br_bus_t;

    typedef struct packed {
        logic     valid;
        id_ctrl_t ctrl;
        word_t    pc;
        instr_u   inst;
        word_t    rdata1;
        word_t    rdata2;
    } id_to_ex_t;

endpackage

`default_nettype wire

// File: hw/id_inst_latch.sv
`timescale 1ns/1ps
`default_nettype none

module id_inst_latch import id_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       stall_if,
    input  logic       stall_id,
    input  fetch_bus_t if_bus,
    input  word_t      inst_rdata,
    output logic       valid,
    output word_t      pc,
    output instr_u     inst
);

    fetch_bus_t fd_q;
    logic       is_stop;
    word_t      hold_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fd_q    <= '0;
            is_stop <= 1'b0;
        end else if (stall_if && !stall_id) begin
            // fetch stalled alone, insert bubble
            fd_q    <= '0;
            is_stop <= 1'b0;
        end else if (!stall_if) begin
            fd_q    <= if_bus;
            is_stop <= 1'b0;
        end else if (stall_id) begin
            is_stop <= 1'b1;
        end
    end

    // tracks memory output until decode stops, then freezes
    always_ff @(posedge clk) begin
        if (!is_stop) begin
            hold_q <= inst_rdata;
        end
    end

    assign valid = fd_q.valid;
    assign pc    = fd_q.pc;
    assign inst  = !fd_q.valid ? '0 : (is_stop ? hold_q : inst_rdata);

endmodule

`default_nettype wire

// File: hw/id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module id_regfile import id_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  fwd_src_t  wr,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [0:31];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wr.we && (wr.waddr == addr)) begin
            // write-back in the same cycle
            val = wr.wdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign rdata1 = read_port(raddr1);
    assign rdata2 = read_port(raddr2);

endmodule

`default_nettype wire

// File: hw/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
    input  logic     valid,
    input  instr_u   inst,
    output id_ctrl_t ctrl,
    output br_kind_t br_kind
);

    logic is_special, is_regimm;
    logic i_addu, i_subu, i_add, i_sub, i_and, i_or, i_xor, i_nor;
    logic i_slt, i_sltu, i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav;
    logic i_addiu, i_addi, i_andi, i_ori, i_xori, i_slti, i_sltiu, i_lui;
    logic i_lw, i_sw, i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz;
    logic i_j, i_jal, i_jr, i_jalr;
    logic r_alu, i_alu;

    assign is_special = (inst.r.opcode == OP_SPECIAL);
    assign is_regimm  = (inst.i.opcode == OP_REGIMM);

    // R-type, selected by funct
    assign i_addu = is_special && (inst.r.funct == FN_ADDU);
    assign i_subu = is_special && (inst.r.funct == FN_SUBU);
    assign i_add  = is_special && (inst.r.funct == FN_ADD);
    assign i_sub  = is_special && (inst.r.funct == FN_SUB);
    assign i_and  = is_special && (inst.r.funct == FN_AND);
    assign i_or   = is_special && (inst.r.funct == FN_OR);
    assign i_xor  = is_special && (inst.r.funct == FN_XOR);
    assign i_nor  = is_special && (inst.r.funct == FN_NOR);
    assign i_slt  = is_special && (inst.r.funct == FN_SLT);
    assign i_sltu = is_special && (inst.r.funct == FN_SLTU);
    assign i_sll  = is_special && (inst.r.funct == FN_SLL);
    assign i_srl  = is_special && (inst.r.funct == FN_SRL);
    assign i_sra  = is_special && (inst.r.funct == FN_SRA);
    assign i_sllv = is_special && (inst.r.funct == FN_SLLV);
    assign i_srlv = is_special && (inst.r.funct == FN_SRLV);
    assign i_srav = is_special && (inst.r.funct == FN_SRAV);
    assign i_jr   = is_special && (inst.r.funct == FN_JR);
    assign i_jalr = is_special && (inst.r.funct == FN_JALR);

    // I-type and J-type by opcode
    assign i_addiu = (inst.i.opcode == OP_ADDIU);
    assign i_addi  = (inst.i.opcode == OP_ADDI);
    assign i_andi  = (inst.i.opcode == OP_ANDI);
    assign i_ori   = (inst.i.opcode == OP_ORI);
    assign i_xori  = (inst.i.opcode == OP_XORI);
    assign i_slti  = (inst.i.opcode == OP_SLTI);
    assign i_sltiu = (inst.i.opcode == OP_SLTIU);
    assign i_lui   = (inst.i.opcode == OP_LUI);
    assign i_lw    = (inst.i.opcode == OP_LW);
    assign i_sw    = (inst.i.opcode == OP_SW);
    assign i_beq   = (inst.i.opcode == OP_BEQ);
    assign i_bne   = (inst.i.opcode == OP_BNE);
    assign i_bgtz  = (inst.i.opcode == OP_BGTZ);
    assign i_blez  = (inst.i.opcode == OP_BLEZ);
    assign i_bgez  = is_regimm && (inst.i.rt == RT_BGEZ);
    assign i_bltz  = is_regimm && (inst.i.rt == RT_BLTZ);
    assign i_j     = (inst.j.opcode == OP_J);
    assign i_jal   = (inst.j.opcode == OP_JAL);

    assign r_alu = i_addu | i_subu | i_add | i_sub | i_and | i_or | i_xor | i_nor |
                   i_slt | i_sltu | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav;
    assign i_alu = i_addiu | i_addi | i_andi | i_ori | i_xori | i_slti | i_sltiu | i_lui;

    // link ops add 8 to pc in execute
    assign ctrl.alu_op.add    = i_addu | i_add | i_addiu | i_addi | i_lw | i_sw | i_jal | i_jalr;
    assign ctrl.alu_op.sub    = i_subu | i_sub;
    assign ctrl.alu_op.slt    = i_slt | i_slti;
    assign ctrl.alu_op.sltu   = i_sltu | i_sltiu;
    assign ctrl.alu_op.op_and = i_and | i_andi;
    assign ctrl.alu_op.op_nor = i_nor;
    assign ctrl.alu_op.op_or  = i_or | i_ori;
    assign ctrl.alu_op.op_xor = i_xor | i_xori;
    assign ctrl.alu_op.sll    = i_sll | i_sllv;
    assign ctrl.alu_op.srl    = i_srl | i_srlv;
    assign ctrl.alu_op.sra    = i_sra | i_srav;
    assign ctrl.alu_op.lui    = i_lui;

    assign ctrl.src1.sa = i_sll | i_srl | i_sra;
    assign ctrl.src1.pc = i_jal | i_jalr;
    assign ctrl.src1.rs = (r_alu & ~ctrl.src1.sa) | (i_alu & ~i_lui) | i_lw | i_sw;

    assign ctrl.src2.rt       = r_alu;
    assign ctrl.src2.imm_sext = i_addi | i_addiu | i_slti | i_sltiu | i_lui | i_lw | i_sw;
    assign ctrl.src2.const8   = i_jal | i_jalr;
    assign ctrl.src2.imm_zext = i_andi | i_ori | i_xori;

    assign ctrl.mem_read   = valid & i_lw;
    assign ctrl.mem_write  = valid & i_sw;
    assign ctrl.rf_we      = valid & (r_alu | i_alu | i_lw | i_jal | i_jalr);
    assign ctrl.sel_rf_res = i_lw;

    // jalr links to 31 here, not rd
    assign ctrl.rf_waddr = ({5{r_alu}} & inst.r.rd) |
                           ({5{i_alu | i_lw}} & inst.i.rt) |
                           ({5{i_jal | i_jalr}} & RA_REG);

    always_comb begin
        br_kind = BR_NONE;
        if (valid) begin
            if (i_beq)       br_kind = BR_BEQ;
            else if (i_bne)  br_kind = BR_BNE;
            else if (i_bgez) br_kind = BR_BGEZ;
            else if (i_bgtz) br_kind = BR_BGTZ;
            else if (i_blez) br_kind = BR_BLEZ;
            else if (i_bltz) br_kind = BR_BLTZ;
            else if (i_j)    br_kind = BR_J;
            else if (i_jal)  br_kind = BR_JAL;
            else if (i_jr)   br_kind = BR_JR;
            else if (i_jalr) br_kind = BR_JALR;
        end
    end

endmodule

`default_nettype wire

// File: hw/id_operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_fwd import id_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  fwd_src_t  ex_fwd,
    input  fwd_src_t  mem_fwd,
    input  logic      ex_mem_read,
    output word_t     rdata1,
    output word_t     rdata2,
    output logic      stall_for_load
);

    // register 0 never matches a producer
    function automatic logic hit(input fwd_src_t src, input reg_addr_t addr);
        return src.we && (addr != '0) && (src.waddr == addr);
    endfunction

    // execute result is newer than memory
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_val);
        word_t val;
        if (hit(ex_fwd, addr)) begin
            val = ex_fwd.wdata;
        end else if (hit(mem_fwd, addr)) begin
            val = mem_fwd.wdata;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign rdata1 = pick(rs, rf_rdata1);
    assign rdata2 = pick(rt, rf_rdata2);

    // load in execute has no data yet
    assign stall_for_load = ex_mem_read && (hit(ex_fwd, rs) || hit(ex_fwd, rt));

endmodule

`default_nettype wire

// File: hw/id_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit import id_pkg::*; (
    input  br_kind_t br_kind,
    input  word_t    pc,
    input  instr_u   inst,
    input  word_t    rdata1,
    input  word_t    rdata2,
    output br_bus_t  br
);

    word_t pc_plus_4;
    word_t br_target;
    word_t jmp_target;
    logic  rs_eq_rt;
    logic  rs_zero;
    logic  rs_neg;

    assign pc_plus_4  = pc + 32'd4;
    assign br_target  = pc_plus_4 + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
    // region jump keeps the top nibble
    assign jmp_target = {pc_plus_4[31:28], inst.j.index, 2'b00};

    assign rs_eq_rt = (rdata1 == rdata2);
    assign rs_zero  = (rdata1 == '0);
    assign rs_neg   = rdata1[31];

    always_comb begin
        br.taken  = 1'b0;
        br.target = '0;
        case (br_kind)
            BR_BEQ: begin
                br.taken  = rs_eq_rt;
                br.target = br_target;
            end
            BR_BNE: begin
                br.taken  = !rs_eq_rt;
                br.target = br_target;
            end
            BR_BGEZ: begin
                br.taken  = !rs_neg;
                br.target = br_target;
            end
            BR_BGTZ: begin
                br.taken  = !rs_neg && !rs_zero;
                br.target = br_target;
            end
            BR_BLEZ: begin
                br.taken  = rs_neg || rs_zero;
                br.target = br_target;
            end
            BR_BLTZ: begin
                br.taken  = rs_neg;
                br.target = br_target;
            end
            BR_J, BR_JAL: begin
                br.taken  = 1'b1;
                br.target = jmp_target;
            end
            BR_JR, BR_JALR: begin
                br.taken  = 1'b1;
                br.target = rdata1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       stall_if,
    input  logic       stall_id,
    input  fetch_bus_t if_bus,
    input  word_t      inst_rdata,
    input  fwd_src_t   ex_fwd,
    input  fwd_src_t   mem_fwd,
    input  fwd_src_t   wb_wr,
    input  logic       ex_mem_read,
    output id_to_ex_t  id_to_ex,
    output br_bus_t    br,
    output logic       stall_for_load
);

    logic     valid;
    word_t    pc;
    instr_u   inst;
    word_t    rf_rdata1, rf_rdata2;
    word_t    rdata1, rdata2;
    id_ctrl_t ctrl;
    br_kind_t br_kind;

    id_inst_latch u_inst_latch (
        .clk(clk), .rst(rst), .flush(flush), .stall_if(stall_if), .stall_id(stall_id),
        .if_bus(if_bus), .inst_rdata(inst_rdata), .valid(valid), .pc(pc), .inst(inst)
    );

    id_regfile u_regfile (
        .clk(clk), .raddr1(inst.r.rs), .raddr2(inst.r.rt), .wr(wb_wr),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    id_decoder u_decoder (.valid(valid), .inst(inst), .ctrl(ctrl), .br_kind(br_kind));

    id_operand_fwd u_operand_fwd (
        .rs(inst.r.rs), .rt(inst.r.rt), .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_fwd(ex_fwd), .mem_fwd(mem_fwd), .ex_mem_read(ex_mem_read),
        .rdata1(rdata1), .rdata2(rdata2), .stall_for_load(stall_for_load)
    );

    id_branch_unit u_branch_unit (
        .br_kind(br_kind), .pc(pc), .inst(inst), .rdata1(rdata1), .rdata2(rdata2), .br(br)
    );

    assign id_to_ex.valid  = valid;
    assign id_to_ex.ctrl   = ctrl;
    assign id_to_ex.pc     = pc;
    assign id_to_ex.inst   = inst;
    assign id_to_ex.rdata1 = rdata1;
    assign id_to_ex.rdata2 = rdata2;

endmodule

`default_nettype wire

// File: include/id_tb_model.svh
`ifndef ID_TB_MODEL_SVH
`define ID_TB_MODEL_SVH

// test kinds
// 0..15 register ALU, 16..23 immediate ALU, 24 lw, 25 sw, 26 beq, 27 bne,
// 28 bgez, 29 bltz, 30 bgtz, 31 blez, 32 j, 33 jal, 34 jr, 35 jalr
localparam int NUM_KINDS = 36;

// register ALU functs in kind order, addu first
localparam logic [15:0][5:0] R_FN = {FN_ADDU, FN_SUBU, FN_ADD, FN_SUB, FN_AND, FN_OR,
    FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
// one-hot ALU flag position, lui is bit 0 and add is bit 11
localparam logic [15:0][3:0] R_BIT = {4'd11, 4'd10, 4'd11, 4'd10, 4'd7, 4'd5, 4'd4, 4'd6,
    4'd9, 4'd8, 4'd3, 4'd2, 4'd1, 4'd3, 4'd2, 4'd1};
localparam logic [7:0][5:0] I_OP = {OP_ADDIU, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
    OP_SLTIU, OP_LUI};
localparam logic [7:0][3:0] I_BIT = {4'd11, 4'd11, 4'd7, 4'd5, 4'd4, 4'd9, 4'd8, 4'd0};
// andi, ori and xori take the zero-extended immediate
localparam logic [7:0] I_ZEXT = 8'b0011_1000;

function automatic word_t encode(input int k, input reg_addr_t rs, input reg_addr_t rt,
                                 input reg_addr_t rd, input logic [15:0] imm);
    word_t w;
    case (k)
        24: w = {OP_LW, rs, rt, imm};
        25: w = {OP_SW, rs, rt, imm};
        26: w = {OP_BEQ, rs, rt, imm};
        27: w = {OP_BNE, rs, rt, imm};
        28: w = {OP_REGIMM, rs, RT_BGEZ, imm};
        29: w = {OP_REGIMM, rs, RT_BLTZ, imm};
        30: w = {OP_BGTZ, rs, 5'd0, imm};
        31: w = {OP_BLEZ, rs, 5'd0, imm};
        32: w = {OP_J, rs, rt, imm};
        33: w = {OP_JAL, rs, rt, imm};
        34: w = {OP_SPECIAL, rs, 10'd0, imm[10:6], FN_JR};
        35: w = {OP_SPECIAL, rs, 5'd0, rd, imm[10:6], FN_JALR};
        default: begin
            if (k < 16) begin
                w = {OP_SPECIAL, rs, rt, rd, imm[10:6], R_FN[15-k]};
            end else begin
                w = {I_OP[23-k], rs, rt, imm};
            end
        end
    endcase
    return w;
endfunction

function automatic id_ctrl_t model_ctrl(input int k, input reg_addr_t rt, input reg_addr_t rd);
    id_ctrl_t c;
    c = '0;
    if (k < 16) begin
        c.alu_op   = 12'h1 << R_BIT[15-k];
        // sll, srl and sra shift by the sa field
        c.src1     = (k >= 10 && k <= 12) ? 3'b001 : 3'b100;
        c.src2     = 4'b1000;
        c.rf_we    = 1'b1;
        c.rf_waddr = rd;
    end else if (k < 24) begin
        c.alu_op   = 12'h1 << I_BIT[23-k];
        c.src1     = (k == 23) ? 3'b000 : 3'b100;
        c.src2     = I_ZEXT[23-k] ? 4'b0001 : 4'b0100;
        c.rf_we    = 1'b1;
        c.rf_waddr = rt;
    end else if (k < 26) begin
        c.alu_op     = 12'h800;
        c.src1       = 3'b100;
        c.src2       = 4'b0100;
        c.mem_read   = (k == 24);
        c.mem_write  = (k == 25);
        c.rf_we      = (k == 24);
        c.rf_waddr   = (k == 24) ? rt : 5'd0;
        c.sel_rf_res = (k == 24);
    end else if (k == 33 || k == 35) begin
        // link value is pc plus 8
        c.alu_op   = 12'h800;
        c.src1     = 3'b010;
        c.src2     = 4'b0010;
        c.rf_we    = 1'b1;
        c.rf_waddr = RA_REG;
    end
    return c;
endfunction

function automatic br_bus_t model_branch(input int k, input word_t pc, input word_t w,
                                         input word_t a, input word_t b);
    br_bus_t r;
    word_t seq;
    logic signed [31:0] a_s;
    seq = pc + 32'd4;
    a_s = a;
    r.target = seq + {{14{w[15]}}, w[15:0], 2'b00};
    case (k)
        26: r.taken = (a == b);
        27: r.taken = (a != b);
        28: r.taken = (a_s >= 0);
        29: r.taken = (a_s < 0);
        30: r.taken = (a_s > 0);
        31: r.taken = (a_s <= 0);
        default: r.taken = (k >= 32);
    endcase
    if (k == 32 || k == 33) begin
        r.target = {seq[31:28], w[25:0], 2'b00};
    end
    if (k >= 34) begin
        r.target = a;
    end
    return r;
endfunction

// execute before memory, register 0 never forwarded
function automatic word_t model_operand(input reg_addr_t addr, input fwd_src_t ex,
                                        input fwd_src_t mem, input word_t rf_val);
    word_t v;
    v = rf_val;
    if (addr != 5'd0 && mem.we && mem.waddr == addr) begin
        v = mem.wdata;
    end
    if (addr != 5'd0 && ex.we && ex.waddr == addr) begin
        v = ex.wdata;
    end
    return v;
endfunction

function automatic logic model_load_stall(input reg_addr_t rs, input reg_addr_t rt,
                                          input fwd_src_t ex, input logic ex_mem_read);
    return ex_mem_read && ex.we && ex.waddr != 5'd0 && (ex.waddr == rs || ex.waddr == rt);
endfunction

`endif

// File: tb/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();

    `include "id_tb_model.svh"

    // about four times the length of the tests
    localparam int MAX_CYCLES = 2000;

    logic       clk;
    logic       rst;
    logic       flush, stall_if, stall_id, ex_mem_read;
    fetch_bus_t if_bus;
    word_t      inst_rdata;
    fwd_src_t   ex_fwd, mem_fwd, wb_wr;
    id_to_ex_t  id_to_ex;
    br_bus_t    br;
    logic       stall_for_load;

    integer    seed;
    int        cycles;
    int        checks;
    int        errors;
    int        i;
    int        k;
    word_t     rf_model [32];
    word_t     rnd;
    word_t     w;
    word_t     pc_val;
    reg_addr_t rs, rt;
    br_bus_t   exp_br;

    id_stage id_stage_inst (
        .clk(clk), .rst(rst), .flush(flush), .stall_if(stall_if), .stall_id(stall_id),
        .if_bus(if_bus), .inst_rdata(inst_rdata), .ex_fwd(ex_fwd), .mem_fwd(mem_fwd),
        .wb_wr(wb_wr), .ex_mem_read(ex_mem_read), .id_to_ex(id_to_ex), .br(br),
        .stall_for_load(stall_for_load)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, tests did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic next_drive();
        @(posedge clk);
        #2;
    endtask

    // instruction sits in decode on return, side inputs idle
    task automatic present(input word_t pc, input word_t instr);
        next_drive();
        if_bus      = {1'b1, pc};
        inst_rdata  = instr;
        ex_fwd      = '0;
        mem_fwd     = '0;
        wb_wr       = '0;
        ex_mem_read = 1'b0;
        next_drive();
    endtask

    task automatic check_idle();
        check_val("id_to_ex.valid", id_to_ex.valid, 0);
        check_val("id_to_ex.inst", id_to_ex.inst, 0);
        check_val("ctrl.rf_we", id_to_ex.ctrl.rf_we, 0);
        check_val("ctrl.mem_read", id_to_ex.ctrl.mem_read, 0);
        check_val("ctrl.mem_write", id_to_ex.ctrl.mem_write, 0);
        check_val("br.taken", br.taken, 0);
        check_val("stall_for_load", stall_for_load, 0);
    endtask

    initial begin
        seed        = 32'h3f1c01dc;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        stall_if    = 1'b0;
        stall_id    = 1'b0;
        ex_mem_read = 1'b0;
        if_bus      = '0;
        inst_rdata  = '0;
        ex_fwd      = '0;
        mem_fwd     = '0;
        wb_wr       = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_idle();

        // decode of every kept instruction
        for (k = 0; k < NUM_KINDS; k++) begin
            rnd    = rand_word();
            pc_val = rand_word() & 32'hffff_fffc;
            w      = encode(k, rnd[4:0], rnd[9:5], rnd[14:10], rnd[31:16]);
            present(pc_val, w);
            @(negedge clk);
            check_val("id_to_ex.valid", id_to_ex.valid, 1);
            check_val("id_to_ex.pc", id_to_ex.pc, pc_val);
            check_val("id_to_ex.inst", id_to_ex.inst, w);
            check_val("id_to_ex.ctrl", id_to_ex.ctrl, model_ctrl(k, rnd[9:5], rnd[14:10]));
        end

        // fill every register through write-back, register 0 included
        for (i = 0; i < 32; i++) begin
            next_drive();
            rnd         = rand_word();
            wb_wr       = {1'b1, i[4:0], rnd};
            rf_model[i] = (i == 0) ? 32'h0 : rnd;
        end
        for (i = 0; i < 32; i++) begin
            present(32'h100, encode(0, i[4:0], ~i[4:0], 5'd1, 16'h0));
            @(negedge clk);
            check_val("id_to_ex.rdata1", id_to_ex.rdata1, rf_model[i]);
            check_val("id_to_ex.rdata2", id_to_ex.rdata2, rf_model[31-i]);
        end

        // read while write-back hits the same register
        for (i = 0; i < 4; i++) begin
            rnd = rand_word();
            rs  = (i == 3) ? 5'd0 : 5'd1 + (rnd[4:0] % 5'd31);
            present(32'h200, encode(0, rs, 5'd0, 5'd1, 16'h0));
            w     = rand_word();
            wb_wr = {1'b1, rs, w};
            @(negedge clk);
            check_val("id_to_ex.rdata1", id_to_ex.rdata1, (rs == 5'd0) ? 32'h0 : w);
            check_val("id_to_ex.rdata2", id_to_ex.rdata2, 0);
            if (rs != 5'd0) begin
                rf_model[rs] = w;
            end
        end

        // forwarding priority and load-use stall
        for (i = 0; i < 60; i++) begin
            rnd = rand_word();
            rs  = {3'b000, rnd[1:0]};
            rt  = {3'b000, rnd[3:2]};
            present(32'h300, encode(0, rs, rt, 5'd4, 16'h0));
            ex_fwd      = {rnd[5:4] != 2'b00, rnd[6] ? rs : rt, rand_word()};
            mem_fwd     = {rnd[8:7] != 2'b00, rnd[9] ? rs : rt, rand_word()};
            ex_mem_read = rnd[10];
            @(negedge clk);
            check_val("id_to_ex.rdata1", id_to_ex.rdata1,
                      model_operand(rs, ex_fwd, mem_fwd, rf_model[rs]));
            check_val("id_to_ex.rdata2", id_to_ex.rdata2,
                      model_operand(rt, ex_fwd, mem_fwd, rf_model[rt]));
            check_val("stall_for_load", stall_for_load,
                      model_load_stall(rs, rt, ex_fwd, rnd[10]));
        end

        // branches and jumps on forwarded operands
        for (i = 0; i < 60; i++) begin
            rnd    = rand_word();
            k      = 26 + (rnd[7:0] % 10);
            rs     = 5'd1 + (rnd[11:8] % 5'd15);
            rt     = rs + 5'd16;
            pc_val = rand_word() & 32'hffff_fffc;
            w      = encode(k, rs, rt, 5'd5, rnd[31:16]);
            present(pc_val, w);
            ex_fwd  = {1'b1, rs, rnd[13] ? 32'h0 : rand_word()};
            mem_fwd = {1'b1, rt, rnd[14] ? ex_fwd.wdata : rand_word()};
            exp_br  = model_branch(k, pc_val, w, ex_fwd.wdata, mem_fwd.wdata);
            @(negedge clk);
            check_val("br.taken", br.taken, exp_br.taken);
            check_val("br.target", br.target, exp_br.target);
        end

        // stopped decode keeps its word while memory output moves on
        w = encode(0, 5'd1, 5'd2, 5'd3, 16'h0);
        present(32'h400, w);
        stall_if = 1'b1;
        stall_id = 1'b1;
        for (i = 0; i < 3; i++) begin
            next_drive();
            inst_rdata = rand_word();
            @(negedge clk);
            check_val("id_to_ex.inst", id_to_ex.inst, w);
            check_val("id_to_ex.valid", id_to_ex.valid, 1);
        end
        next_drive();
        stall_id = 1'b0;
        // fetch stalled alone gives a bubble
        next_drive();
        stall_if = 1'b0;
        @(negedge clk);
        check_idle();

        // flush drops a taken jump
        present(32'h500, encode(32, 5'd0, 5'd0, 5'd0, 16'h40));
        @(negedge clk);
        check_val("br.taken", br.taken, 1);
        next_drive();
        flush = 1'b1;
        next_drive();
        flush = 1'b0;
        @(negedge clk);
        check_idle();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hw/id_pkg.sv
hw/id_inst_latch.sv
hw/id_regfile.sv
hw/id_decoder.sv
hw/id_operand_fwd.sv
hw/id_branch_unit.sv
hw/id_stage.sv
tb/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - files:
      - hw/id_pkg.sv
      - hw/id_inst_latch.sv
      - hw/id_regfile.sv
      - hw/id_decoder.sv
      - hw/id_operand_fwd.sv
      - hw/id_branch_unit.sv
      - hw/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/id_stage_tb.sv
